//--- design/rvPkg.sv
`default_nettype none

package rvPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcode;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluPassB = 3'd4
    } aluOp;

    typedef enum logic [1:0] {
        fwdRegFile = 2'b00,
        fwdMem     = 2'b01,
        fwdWb      = 2'b10
    } fwdSel;

    // Top bit set means any jump
    typedef enum logic [1:0] {
        jumpNone = 2'b00,
        jumpRsvd = 2'b01,
        jumpJal  = 2'b10,
        jumpJalr = 2'b11
    } jumpKind;

    localparam logic traceReg   = 1'b0;
    localparam logic traceStore = 1'b1;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        aluOp        alu;
        logic        useImm;
        logic        isLoad;
        logic        isStore;
        logic        isBranch;
        logic        regWrite;
        jumpKind     jump;
        logic [31:0] pc;
    } decodedInstr;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] result;     // ALU output or link value
        logic [31:0] storeData;
        logic        isLoad;
        logic        isStore;
        logic        regWrite;
        logic [31:0] pc;
    } execResult;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic        regWrite;
    } wbRecord;

    typedef struct packed {
        logic        kind;       // traceReg or traceStore
        logic [31:0] addr;       // Register number for writes
        logic [31:0] value;
    } traceRecord;

endpackage

`default_nettype wire

//--- design/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit
    import rvPkg::*;
(
    input  logic [4:0] rs1E,
    input  logic [4:0] rs2E,
    input  logic [4:0] rdM,
    input  logic [4:0] rdW,
    input  logic       isLoadM,
    input  logic       branchE,
    input  jumpKind    jumpE,
    input  logic       eq,
    output fwdSel      forwardA,
    output fwdSel      forwardB,
    output logic       stall,
    output logic       flush
);

    // Memory stage wins over writeback when both hold the register
    // A stage writing x0 has nothing to forward
    function automatic fwdSel pickForward(input logic [4:0] rs,
                                          input logic [4:0] rdMem,
                                          input logic [4:0] rdWb);
        if (rdMem != 5'd0 && rs == rdMem) begin
            return fwdMem;
        end else if (rdWb != 5'd0 && rs == rdWb) begin
            return fwdWb;
        end
        return fwdRegFile;
    endfunction

    assign forwardA = pickForward(rs1E, rdM, rdW);
    assign forwardB = pickForward(rs2E, rdM, rdW);

    // Load result not ready until writeback
    always_comb begin
        stall = 1'b0;
        if (isLoadM && rdM != 5'd0 && (rdM == rs1E || rdM == rs2E)) begin
            stall = 1'b1;
        end
    end

    // Wait for load data before resolving a branch or JALR
    always_comb begin
        flush = 1'b0;
        if (jumpE[1] || (branchE && eq)) begin
            flush = !stall;
        end
    end

    always_comb begin
        assert (rs1E != 5'd0 || forwardA == fwdRegFile)
            else $error("Forward selected for x0 on rs1");
    end

endmodule

`default_nettype wire

//--- design/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage
    import rvPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  wbRecord     wb,
    output decodedInstr decoded,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];
    opcode       op;
    logic [2:0]  funct3;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;

    assign op     = opcode'(instr[6:0]);
    assign funct3 = instr[14:12];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoded    = '0;  // Bubble unless recognised
        decoded.pc = pc;
        case (op)
            opReg: begin
                decoded.rs1      = instr[19:15];
                decoded.rs2      = instr[24:20];
                decoded.rd       = instr[11:7];
                decoded.regWrite = 1'b1;
                case (funct3)
                    3'b000:  decoded.alu = instr[30] ? aluSub : aluAdd;
                    3'b110:  decoded.alu = aluOr;
                    3'b111:  decoded.alu = aluAnd;
                    default: decoded = '0;
                endcase
            end
            opImm, opLoad: begin
                decoded.rs1      = instr[19:15];
                decoded.rd       = instr[11:7];
                decoded.imm      = immI;
                decoded.useImm   = 1'b1;
                decoded.isLoad   = (op == opLoad);
                decoded.regWrite = 1'b1;
            end
            opStore: begin
                decoded.rs1     = instr[19:15];
                decoded.rs2     = instr[24:20];
                decoded.imm     = immS;
                decoded.useImm  = 1'b1;
                decoded.isStore = 1'b1;
            end
            opBranch: begin
                decoded.rs1      = instr[19:15];
                decoded.rs2      = instr[24:20];
                decoded.imm      = immB;
                decoded.isBranch = 1'b1;
            end
            opJal, opJalr: begin
                decoded.rs1      = (op == opJalr) ? instr[19:15] : 5'd0;
                decoded.rd       = instr[11:7];
                decoded.imm      = (op == opJalr) ? immI : immJ;
                decoded.alu      = aluPassB;  // Link value rides on operand B
                decoded.regWrite = 1'b1;
                decoded.jump     = (op == opJalr) ? jumpJalr : jumpJal;
            end
            default: decoded = '0;
        endcase
        if (decoded.rd == 5'd0) begin
            decoded.regWrite = 1'b0;  // x0 is never written
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Same-cycle writeback bypasses the array
    function automatic logic [31:0] readReg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wb.regWrite && wb.rd == idx) begin
            return wb.value;
        end
        return regs[idx];
    endfunction

    assign rs1Data = readReg(decoded.rs1);
    assign rs2Data = readReg(decoded.rs2);

endmodule

`default_nettype wire

//--- design/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage
    import rvPkg::*;
(
    input  decodedInstr decoded,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    input  logic [31:0] memFwd,
    input  logic [31:0] wbFwd,
    input  fwdSel       forwardA,
    input  fwdSel       forwardB,
    output execResult   result,
    output logic        eq,
    output logic [31:0] target
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] srcB;
    logic [31:0] linkPc;
    logic [31:0] aluOut;

    function automatic logic [31:0] pickOperand(input fwdSel sel,
                                                input logic [31:0] rfData,
                                                input logic [31:0] memData,
                                                input logic [31:0] wbData);
        case (sel)
            fwdMem:  return memData;
            fwdWb:   return wbData;
            default: return rfData;
        endcase
    endfunction

    assign opA    = pickOperand(forwardA, rs1Data, memFwd, wbFwd);
    assign opB    = pickOperand(forwardB, rs2Data, memFwd, wbFwd);
    assign linkPc = decoded.pc + 32'd4;

    // Jumps pass pc+4 through as the link value
    assign srcB = decoded.jump[1] ? linkPc : (decoded.useImm ? decoded.imm : opB);

    always_comb begin
        case (decoded.alu)
            aluAdd:   aluOut = opA + srcB;
            aluSub:   aluOut = opA - srcB;
            aluAnd:   aluOut = opA & srcB;
            aluOr:    aluOut = opA | srcB;
            default:  aluOut = srcB;
        endcase
    end

    assign eq = (opA == opB);  // BEQ compare

    always_comb begin
        if (decoded.jump == jumpJalr) begin
            target = (opA + decoded.imm) & ~32'd1;
        end else begin
            target = decoded.pc + decoded.imm;  // JAL and branches
        end
    end

    always_comb begin
        result.rd        = decoded.rd;
        result.result    = aluOut;
        result.storeData = opB;
        result.isLoad    = decoded.isLoad;
        result.isStore   = decoded.isStore;
        result.regWrite  = decoded.regWrite;
        result.pc        = decoded.pc;
    end

endmodule

`default_nettype wire

//--- design/dataMemory.sv
`timescale 1ns/100ps
`default_nettype none

module dataMemory #(
    parameter int dmemDepth = 64
) (
    input  logic        clk,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int idxW = $clog2(dmemDepth);

    logic [31:0]     mem [dmemDepth];
    logic [idxW-1:0] idx;

    assign idx = addr[idxW+1:2];  // Word index from byte address

    // Load data shows up one cycle after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
        rdata <= mem[idx];
    end

    addrInRange: assert property (@(posedge clk) addr[31:2] < 30'(dmemDepth))
        else $error("Data access at %h outside memory", addr);

endmodule

`default_nettype wire

//--- design/pipelineCore.sv
`timescale 1ns/100ps
`default_nettype none

module pipelineCore
    import rvPkg::*;
#(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        run,
    input  logic        progWe,
    input  logic [31:0] progAddr,  // Word index
    input  logic [31:0] progData,
    output logic        traceValid,
    output traceRecord  trace
);

    localparam int imemIdxW = $clog2(imemDepth);

    logic [31:0] imem [imemDepth];
    logic [31:0] pcF;
    logic [31:0] instrF;
    logic [31:0] instrD;
    logic [31:0] pcD;
    decodedInstr decodedD;
    decodedInstr decE;
    logic [31:0] rs1DataD;
    logic [31:0] rs2DataD;
    logic [31:0] rs1DataE;
    logic [31:0] rs2DataE;
    execResult   resultE;
    execResult   exMem;
    wbRecord     memWb;
    wbRecord     wbW;
    logic        loadW;
    logic        storeW;
    traceRecord  storeTraceW;
    logic [31:0] dmemAddr;
    logic [31:0] dmemRdata;
    logic [31:0] targetE;
    logic        eqE;
    logic        stall;
    logic        flush;
    fwdSel       forwardA;
    fwdSel       forwardB;

    // Program load only while the core is held
    always_ff @(posedge clk) begin
        if (progWe && !run) begin
            imem[progAddr[imemIdxW-1:0]] <= progData;
        end
    end

    assign instrF = imem[pcF[imemIdxW+1:2]];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= '0;
        end else if (!run) begin
            pcF <= '0;
        end else if (flush) begin
            pcF <= targetE;
        end else if (!stall) begin
            pcF <= pcF + 32'd4;
        end
    end

    // An all-zero word in fetch/decode decodes as a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= '0;
            pcD    <= '0;
        end else if (!run || flush) begin
            instrD <= '0;
            pcD    <= '0;
        end else if (!stall) begin
            instrD <= instrF;
            pcD    <= pcF;
        end
    end

    decodeStage uDecode (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instrD),
        .pc      (pcD),
        .wb      (wbW),
        .decoded (decodedD),
        .rs1Data (rs1DataD),
        .rs2Data (rs2DataD)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decE <= '0;
        end else if (!run || flush) begin
            decE <= '0;
        end else if (!stall) begin
            decE <= decodedD;
        end
    end

    // Operand payload captures a writeback forward before it retires
    always_ff @(posedge clk) begin
        if (!stall) begin
            rs1DataE <= rs1DataD;
            rs2DataE <= rs2DataD;
        end else begin
            if (forwardA == fwdWb) begin
                rs1DataE <= wbW.value;
            end
            if (forwardB == fwdWb) begin
                rs2DataE <= wbW.value;
            end
        end
    end

    hazardUnit uHazard (
        .rs1E     (decE.rs1),
        .rs2E     (decE.rs2),
        .rdM      (exMem.rd),
        .rdW      (memWb.rd),
        .isLoadM  (exMem.isLoad),
        .branchE  (decE.isBranch),
        .jumpE    (decE.jump),
        .eq       (eqE),
        .forwardA (forwardA),
        .forwardB (forwardB),
        .stall    (stall),
        .flush    (flush)
    );

    executeStage uExecute (
        .decoded  (decE),
        .rs1Data  (rs1DataE),
        .rs2Data  (rs2DataE),
        .memFwd   (exMem.result),
        .wbFwd    (wbW.value),
        .forwardA (forwardA),
        .forwardB (forwardB),
        .result   (resultE),
        .eq       (eqE),
        .target   (targetE)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else if (!run || stall) begin
            exMem <= '0;  // Bubble behind a load-use stall
        end else begin
            exMem <= resultE;
        end
    end

    // Only real memory ops drive an address
    assign dmemAddr = (exMem.isLoad || exMem.isStore) ? exMem.result : '0;

    dataMemory #(
        .dmemDepth (dmemDepth)
    ) uDataMem (
        .clk   (clk),
        .we    (exMem.isStore),
        .addr  (dmemAddr),
        .wdata (exMem.storeData),
        .rdata (dmemRdata)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb  <= '0;
            loadW  <= 1'b0;
            storeW <= 1'b0;
        end else if (!run) begin
            memWb  <= '0;
            loadW  <= 1'b0;
            storeW <= 1'b0;
        end else begin
            memWb.rd       <= exMem.rd;
            memWb.value    <= exMem.result;
            memWb.regWrite <= exMem.regWrite;
            loadW          <= exMem.isLoad;
            storeW         <= exMem.isStore;
        end
    end

    // Store record leaves memory together with its retirement slot
    always_ff @(posedge clk) begin
        storeTraceW.kind  <= traceStore;
        storeTraceW.addr  <= exMem.result;
        storeTraceW.value <= exMem.storeData;
    end

    always_comb begin
        wbW.rd       = memWb.rd;
        wbW.value    = loadW ? dmemRdata : memWb.value;
        wbW.regWrite = memWb.regWrite;
    end

    always_comb begin
        trace      = storeTraceW;
        traceValid = storeW;
        if (wbW.regWrite) begin
            trace.kind  = traceReg;
            trace.addr  = {27'd0, wbW.rd};
            trace.value = wbW.value;
            traceValid  = 1'b1;
        end
    end

    quietWhileHeld: assert property (@(posedge clk) disable iff (!rstN)
        !run ##1 !run |-> !traceValid)
        else $error("Trace activity while core is held");

endmodule

`default_nettype wire

//--- verification/coreTb.sv
`timescale 1ns/100ps
`default_nettype none

module coreTb
    import rvPkg::*;
;

    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;
    localparam int patDepth  = 256;
    localparam logic [31:0] sepWord = 32'hffffffff;  // Ends program and record list

    logic        clk;
    logic        rstN;
    logic        run;
    logic        progWe;
    logic [31:0] progAddr;
    logic [31:0] progData;
    logic        traceValid;
    traceRecord  trace;

    logic [31:0] patWords [patDepth];
    int          progLen;
    int          recBase;
    int          numRecords;
    int          recIdx;
    logic        running;

    pipelineCore #(
        .imemDepth (imemDepth),
        .dmemDepth (dmemDepth)
    ) dut (
        .clk        (clk),
        .rstN       (rstN),
        .run        (run),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .traceValid (traceValid),
        .trace      (trace)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual,
                     expected);
            abortRun();
        end
    endtask

    // Program words, then records of kind, address or register, value
    task automatic readPatterns();
        int idx;
        $readmemh("verification/corePatterns.txt", patWords);
        idx = 0;
        while (idx < patDepth && patWords[idx] !== sepWord) begin
            idx++;
        end
        progLen = idx;
        recBase = idx + 1;
        idx = recBase;
        while (idx < patDepth && patWords[idx] !== sepWord) begin
            idx += 3;
        end
        numRecords = (idx - recBase) / 3;
        if (progLen > imemDepth || idx >= patDepth || numRecords == 0) begin
            $display("Pattern file is malformed: missing marker, empty list or long program");
            abortRun();
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= 32'(i);  // Word index
            progData <= patWords[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic checkRecord(input int r);
        int base;
        base = recBase + 3 * r;
        compareValue({31'd0, trace.kind}, patWords[base], $sformatf("record %0d kind", r));
        compareValue(trace.addr, patWords[base + 1], $sformatf("record %0d address", r));
        compareValue(trace.value, patWords[base + 2], $sformatf("record %0d value", r));
    endtask

    // Mid-cycle sampling of the trace port
    always @(negedge clk) begin
        if (running && traceValid) begin
            if (recIdx >= numRecords) begin
                $display("Unexpected trace record at %0t after the last expected one", $time);
                abortRun();
            end else begin
                checkRecord(recIdx);
                recIdx = recIdx + 1;
            end
        end
    end

    initial begin
        rstN     = 1'b0;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        recIdx   = 0;
        running  = 1'b0;
        readPatterns();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        loadProgram();
        @(posedge clk);
        run <= 1'b1;
        running = 1'b1;
        wait (recIdx == numRecords);
        repeat (20) @(posedge clk);  // Room for stray records
        $display("Done: no errors");
        $finish;
    end

    initial begin
        wait (running);
        repeat (40 * numRecords + 100) @(posedge clk);
        $display("Timeout: trace stalled after %0d of %0d records", recIdx, numRecords);
        abortRun();
    end

endmodule

`default_nettype wire

//--- list.f
design/rvPkg.sv
design/hazardUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/dataMemory.sv
design/pipelineCore.sv
verification/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= coreTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
PASS_MSG  ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator status is only recorded
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/corePatterns.txt
// Program words first, four per line, then ffffffff, then expected trace records
// Record columns: kind (0 register write, 1 store), register or byte address, value
00500093 00700113 002081b3 001181b3  // addi x1, addi x2, add x3, add x3
40218233 003262b3 0022f333 04000393  // sub x4, or x5, and x6, addi x7
0053a023 0063a223 0003a403 002404b3  // sw x5, sw x6, lw x8, add x9 load-use
0043a503 00a505b3 00208463 00100613  // lw x10, add x11, beq not taken, addi x12
00c60663 06300693 06300713 05500793  // beq taken, two skipped, addi x15
00c0086f 06300893 06200893 07000913  // jal x16, two skipped, addi x18
000909e7 06300a13 06200a13 06100a93  // jalr x19, three never run
00508013 00100b33 0163a423 0083ab83  // addi x0, add x22, sw x22, lw x23
001b8463 06300c13 02a00c93 0000006f  // beq after load, skipped, addi x25, self loop
ffffffff
0 00000001 00000005
0 00000002 00000007
0 00000003 0000000c
0 00000003 00000011
0 00000004 0000000a
0 00000005 0000001b
0 00000006 00000003
0 00000007 00000040
1 00000040 0000001b
1 00000044 00000003
0 00000008 0000001b
0 00000009 00000022
0 0000000a 00000003
0 0000000b 00000006
0 0000000c 00000001
0 0000000f 00000055
0 00000010 00000054
0 00000012 00000070
0 00000013 00000064
0 00000016 00000005
1 00000048 00000005
0 00000017 00000005
0 00000019 0000002a
ffffffff
